// File: sram_axi_read_bridge.f
+incdir+include
source/axi_bridge_pkg.sv
source/read_req_decode.sv
source/read_arbiter.sv
source/read_return_router.sv
source/sram_axi_read_bridge.sv
tests/axi_read_slave_model.sv
tests/tb_sram_axi_read_bridge.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_sram_axi_read_bridge
FILELIST  = sram_axi_read_bridge.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_sram_axi_read_bridge.sv
// read bridge testbench
`include "axi_bridge_params.svh"

module tb_sram_axi_read_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 6;
    localparam int WAIT_LIMIT = 20;
    localparam int RUN_LIMIT = 200;

    // one requester's stimulus and what the bus should show for it
    typedef struct {
        logic                       valid;
        axi_bridge_pkg::req_kind_e  kind;
        logic [31:0]                addr;
        logic [2:0]                 size;
        logic [31:0]                ar_addr;
        logic [7:0]                 ar_len;
        logic [2:0]                 ar_size;
        axi_bridge_pkg::axi_burst_e ar_burst;
        int                         beats;
        logic [0:3][31:0]           words;
    } side_t;

    typedef struct {
        string name;
        side_t inst;
        side_t data;
        logic  short_last;
        logic  slverr;
        logic  exp_err;
    } row_t;

    logic                       clk;
    logic                       reset;
    logic                       inst_req_valid;
    logic                       inst_req_ready;
    axi_bridge_pkg::req_kind_e  inst_req_kind;
    logic [`AXI_ADDR_WIDTH-1:0] inst_req_addr;
    logic [`AXI_SIZE_WIDTH-1:0] inst_req_size;
    logic                       inst_ret_valid;
    logic [`AXI_DATA_WIDTH-1:0] inst_ret_data;
    logic                       inst_ret_last;
    logic                       data_req_valid;
    logic                       data_req_ready;
    axi_bridge_pkg::req_kind_e  data_req_kind;
    logic [`AXI_ADDR_WIDTH-1:0] data_req_addr;
    logic [`AXI_SIZE_WIDTH-1:0] data_req_size;
    logic                       data_ret_valid;
    logic [`AXI_DATA_WIDTH-1:0] data_ret_data;
    logic                       data_ret_last;
    logic                       arvalid;
    logic                       arready;
    logic [`AXI_ADDR_WIDTH-1:0] araddr;
    logic [`AXI_LEN_WIDTH-1:0]  arlen;
    logic [`AXI_SIZE_WIDTH-1:0] arsize;
    axi_bridge_pkg::axi_burst_e arburst;
    logic                       rvalid;
    logic [`AXI_DATA_WIDTH-1:0] rdata;
    logic [`AXI_RESP_WIDTH-1:0] rresp;
    logic                       rlast;
    logic                       resp_error;
    logic                       short_last;
    logic                       slverr;

    row_t rows [NUM_TESTS];
    int   checks;
    int   errors;
    bit   timed_out;

    sram_axi_read_bridge u_dut (
        .clk              (clk),
        .reset            (reset),
        .i_inst_req_valid (inst_req_valid),
        .o_inst_req_ready (inst_req_ready),
        .i_inst_req_kind  (inst_req_kind),
        .i_inst_req_addr  (inst_req_addr),
        .i_inst_req_size  (inst_req_size),
        .o_inst_ret_valid (inst_ret_valid),
        .o_inst_ret_data  (inst_ret_data),
        .o_inst_ret_last  (inst_ret_last),
        .i_data_req_valid (data_req_valid),
        .o_data_req_ready (data_req_ready),
        .i_data_req_kind  (data_req_kind),
        .i_data_req_addr  (data_req_addr),
        .i_data_req_size  (data_req_size),
        .o_data_ret_valid (data_ret_valid),
        .o_data_ret_data  (data_ret_data),
        .o_data_ret_last  (data_ret_last),
        .o_arvalid        (arvalid),
        .i_arready        (arready),
        .o_araddr         (araddr),
        .o_arlen          (arlen),
        .o_arsize         (arsize),
        .o_arburst        (arburst),
        .i_rvalid         (rvalid),
        .i_rdata          (rdata),
        .i_rresp          (rresp),
        .i_rlast          (rlast),
        .o_resp_error     (resp_error)
    );

    axi_read_slave_model u_slave (
        .clk          (clk),
        .reset        (reset),
        .i_arvalid    (arvalid),
        .o_arready    (arready),
        .i_araddr     (araddr),
        .i_arlen      (arlen),
        .i_arburst    (arburst),
        .o_rvalid     (rvalid),
        .o_rdata      (rdata),
        .o_rresp      (rresp),
        .o_rlast      (rlast),
        .i_short_last (short_last),
        .i_slverr     (slverr)
    );

    // 100 ns period
    always #50 clk = ~clk;

    function automatic side_t make_side(
        input axi_bridge_pkg::req_kind_e  kind,
        input logic [31:0]                addr,
        input logic [2:0]                 size,
        input logic [31:0]                ar_addr,
        input logic [7:0]                 ar_len,
        input logic [2:0]                 ar_size,
        input axi_bridge_pkg::axi_burst_e ar_burst,
        input int                         beats,
        input logic [0:3][31:0]           words
    );
        side_t s;
        s.valid = 1'b1;
        s.kind = kind;
        s.addr = addr;
        s.size = size;
        s.ar_addr = ar_addr;
        s.ar_len = ar_len;
        s.ar_size = ar_size;
        s.ar_burst = ar_burst;
        s.beats = beats;
        s.words = words;
        return s;
    endfunction

    // requester left idle for the row
    function automatic side_t no_side();
        side_t s;
        s = make_side(axi_bridge_pkg::KIND_SINGLE, '0, '0, '0, '0, '0,
                      axi_bridge_pkg::BURST_FIXED, 0, '0);
        s.valid = 1'b0;
        return s;
    endfunction

    // expected words are word address ^ 32'hA5A5_0000
    task automatic fill_rows();
        rows[0] = '{"inst_single",
            make_side(axi_bridge_pkg::KIND_SINGLE, 32'h0000_1006, 3'd1, 32'h0000_1006,
                      8'd0, 3'd1, axi_bridge_pkg::BURST_FIXED, 1,
                      {32'hA5A5_0401, 32'h0, 32'h0, 32'h0}),
            no_side(), 1'b0, 1'b0, 1'b0};
        // unaligned line address snaps to the line base
        rows[1] = '{"data_line", no_side(),
            make_side(axi_bridge_pkg::KIND_LINE, 32'h0000_2008, 3'd0, 32'h0000_2000,
                      8'd3, 3'd2, axi_bridge_pkg::BURST_INCR, 4,
                      {32'hA5A5_0800, 32'hA5A5_0801, 32'hA5A5_0802, 32'hA5A5_0803}),
            1'b0, 1'b0, 1'b0};
        rows[2] = '{"tie",
            make_side(axi_bridge_pkg::KIND_LINE, 32'h0000_3014, 3'd2, 32'h0000_3010,
                      8'd3, 3'd2, axi_bridge_pkg::BURST_INCR, 4,
                      {32'hA5A5_0C04, 32'hA5A5_0C05, 32'hA5A5_0C06, 32'hA5A5_0C07}),
            make_side(axi_bridge_pkg::KIND_SINGLE, 32'h0000_4000, 3'd2, 32'h0000_4000,
                      8'd0, 3'd2, axi_bridge_pkg::BURST_FIXED, 1,
                      {32'hA5A5_1000, 32'h0, 32'h0, 32'h0}),
            1'b0, 1'b0, 1'b0};
        // rlast on the third beat of four
        rows[3] = '{"short_last", no_side(),
            make_side(axi_bridge_pkg::KIND_LINE, 32'h0000_500C, 3'd2, 32'h0000_5000,
                      8'd3, 3'd2, axi_bridge_pkg::BURST_INCR, 3,
                      {32'hA5A5_1400, 32'hA5A5_1401, 32'hA5A5_1402, 32'h0}),
            1'b1, 1'b0, 1'b1};
        rows[4] = '{"slverr",
            make_side(axi_bridge_pkg::KIND_SINGLE, 32'h0000_6000, 3'd2, 32'h0000_6000,
                      8'd0, 3'd2, axi_bridge_pkg::BURST_FIXED, 1,
                      {32'hA5A5_1800, 32'h0, 32'h0, 32'h0}),
            no_side(), 1'b0, 1'b1, 1'b1};
        rows[5] = '{"clean_after_reset", no_side(),
            make_side(axi_bridge_pkg::KIND_SINGLE, 32'h0000_7004, 3'd2, 32'h0000_7004,
                      8'd0, 3'd2, axi_bridge_pkg::BURST_FIXED, 1,
                      {32'hA5A5_1C01, 32'h0, 32'h0, 32'h0}),
            1'b0, 1'b0, 1'b0};
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one return beat against the side's expected words
    task automatic check_return(input string name, input side_t s, inout int cnt,
                                input logic [31:0] data, input logic last);
        if (cnt >= s.beats) begin
            errors++;
            $display("%s: return beat arrived with no read outstanding for it", name);
        end else begin
            check_value({name, " data"}, s.words[cnt], data);
            check_value({name, " last"}, 32'(cnt == s.beats - 1), 32'(last));
            cnt++;
        end
    endtask

    // three cycles of reset then the idle outputs
    task automatic apply_reset(input string name);
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value({name, " reset arvalid"}, 32'd0, 32'(arvalid));
        check_value({name, " reset inst_ret_valid"}, 32'd0, 32'(inst_ret_valid));
        check_value({name, " reset data_ret_valid"}, 32'd0, 32'(data_ret_valid));
        check_value({name, " reset resp_error"}, 32'd0, 32'(resp_error));
        check_value({name, " reset inst_req_ready"}, 32'd1, 32'(inst_req_ready));
        check_value({name, " reset data_req_ready"}, 32'd1, 32'(data_req_ready));
    endtask

    task automatic run_row(input int idx);
        row_t  r;
        side_t ar_order [2];
        int    n_ar;
        int    ar_idx;
        int    inst_cnt;
        int    data_cnt;
        int    cycles;
        bit    finished;
        r = rows[idx];
        n_ar = 0;
        ar_idx = 0;
        inst_cnt = 0;
        data_cnt = 0;
        finished = 1'b0;
        // data wins the tie, so its read goes out first
        if (r.data.valid) begin
            ar_order[n_ar] = r.data;
            n_ar++;
        end
        if (r.inst.valid) begin
            ar_order[n_ar] = r.inst;
            n_ar++;
        end
        apply_reset(r.name);
        @(posedge clk);
        short_last <= r.short_last;
        slverr <= r.slverr;
        inst_req_valid <= r.inst.valid;
        inst_req_kind <= r.inst.kind;
        inst_req_addr <= r.inst.addr;
        inst_req_size <= r.inst.size;
        data_req_valid <= r.data.valid;
        data_req_kind <= r.data.kind;
        data_req_addr <= r.data.addr;
        data_req_size <= r.data.size;
        // both requests in the same cycle
        for (cycles = 0; cycles < WAIT_LIMIT; cycles++) begin
            @(negedge clk);
            if ((!r.inst.valid || inst_req_ready) && (!r.data.valid || data_req_ready)) begin
                break;
            end
        end
        if (cycles == WAIT_LIMIT) begin
            $display("timeout: test %s, request was never accepted", r.name);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        inst_req_valid <= 1'b0;
        data_req_valid <= 1'b0;
        for (cycles = 0; cycles < RUN_LIMIT && !finished; cycles++) begin
            @(negedge clk);
            // ar fields checked on every cycle of back-pressure
            if (arvalid) begin
                if (ar_idx >= n_ar) begin
                    errors++;
                    $display("test %s: AR issued with no request left to issue", r.name);
                end else begin
                    check_value({r.name, " araddr"}, ar_order[ar_idx].ar_addr, araddr);
                    check_value({r.name, " arlen"}, 32'(ar_order[ar_idx].ar_len), 32'(arlen));
                    check_value({r.name, " arsize"}, 32'(ar_order[ar_idx].ar_size),
                                32'(arsize));
                    check_value({r.name, " arburst"}, 32'(ar_order[ar_idx].ar_burst),
                                32'(arburst));
                end
                if (arready) begin
                    ar_idx++;
                end
            end
            if (inst_ret_valid) begin
                check_return({r.name, " inst"}, r.inst, inst_cnt, inst_ret_data, inst_ret_last);
            end
            if (data_ret_valid) begin
                check_return({r.name, " data"}, r.data, data_cnt, data_ret_data, data_ret_last);
            end
            finished = (ar_idx == n_ar) && (inst_cnt == r.inst.beats) &&
                       (data_cnt == r.data.beats);
        end
        if (!finished) begin
            $display("timeout: test %s did not finish its reads", r.name);
            timed_out = 1'b1;
        end else begin
            check_value({r.name, " resp_error"}, 32'(r.exp_err), 32'(resp_error));
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        inst_req_valid = 1'b0;
        inst_req_kind = axi_bridge_pkg::KIND_SINGLE;
        inst_req_addr = '0;
        inst_req_size = '0;
        data_req_valid = 1'b0;
        data_req_kind = axi_bridge_pkg::KIND_SINGLE;
        data_req_addr = '0;
        data_req_size = '0;
        short_last = 1'b0;
        slverr = 1'b0;
        checks = 0;
        errors = 0;
        timed_out = 1'b0;
        fill_rows();
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (!timed_out) begin
                run_row(i);
            end
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/axi_read_slave_model.sv
// axi read slave model
`include "axi_bridge_params.svh"

module axi_read_slave_model (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_arvalid,
    output logic                       o_arready,
    input  logic [`AXI_ADDR_WIDTH-1:0] i_araddr,
    input  logic [`AXI_LEN_WIDTH-1:0]  i_arlen,
    input  axi_bridge_pkg::axi_burst_e i_arburst,
    output logic                       o_rvalid,
    output logic [`AXI_DATA_WIDTH-1:0] o_rdata,
    output logic [`AXI_RESP_WIDTH-1:0] o_rresp,
    output logic                       o_rlast,
    input  logic                       i_short_last,
    input  logic                       i_slverr
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [31:0] DATA_MASK = 32'hA5A5_0000;

    logic [31:0]               lfsr_q;
    logic [31:0]               lfsr_mid;
    logic [1:0]                draw;
    logic [1:0]                delay_q;
    logic                      busy_q;
    logic                      incr_q;
    logic [31:0]               word_q;
    logic [`AXI_LEN_WIDTH-1:0] len_q;
    logic [`AXI_LEN_WIDTH-1:0] beat_q;
    logic                      last_beat;

    // galois form, shifts right
    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        if (value[0]) begin
            return (value >> 1) ^ LFSR_TAPS;
        end
        return value >> 1;
    endfunction

    initial begin
        lfsr_q = 32'he285b59b;
    end

    // two bits per delay draw, one lfsr step each
    assign lfsr_mid = lfsr_step(lfsr_q);
    assign draw = {lfsr_mid[0], lfsr_q[0]};

    // injected fault ends the burst one beat early
    assign last_beat = (beat_q == len_q) || (i_short_last && beat_q + 8'd1 == len_q);

    always @(posedge clk) begin
        if (reset) begin
            o_arready <= 1'b0;
            o_rvalid <= 1'b0;
            o_rlast <= 1'b0;
            o_rresp <= 2'b00;
            busy_q <= 1'b0;
            delay_q <= draw;
            lfsr_q <= lfsr_step(lfsr_mid);
        end else begin
            o_rvalid <= 1'b0;
            o_rlast <= 1'b0;
            if (busy_q) begin
                // data is the beat's word address under a mask
                o_rvalid <= 1'b1;
                o_rdata <= (word_q + (incr_q ? 32'(beat_q) : 32'd0)) ^ DATA_MASK;
                o_rresp <= i_slverr ? 2'b10 : 2'b00;
                o_rlast <= last_beat;
                beat_q <= beat_q + 8'd1;
                if (last_beat) begin
                    busy_q <= 1'b0;
                end
            end else if (i_arvalid && o_arready) begin
                o_arready <= 1'b0;
                busy_q <= 1'b1;
                word_q <= i_araddr >> 2;
                len_q <= i_arlen;
                incr_q <= (i_arburst == axi_bridge_pkg::BURST_INCR);
                beat_q <= '0;
                // next delay
                delay_q <= draw;
                lfsr_q <= lfsr_step(lfsr_mid);
            end else if (i_arvalid) begin
                // hold arready low for 0 to 3 cycles
                if (delay_q == 2'd0) begin
                    o_arready <= 1'b1;
                end else begin
                    delay_q <= delay_q - 2'd1;
                end
            end
        end
    end

endmodule

// File: source/sram_axi_read_bridge.sv
// sram-like to axi read bridge
`include "axi_bridge_params.svh"

module sram_axi_read_bridge (
    input  logic                       clk,
    input  logic                       reset,
    // instruction side
    input  logic                       i_inst_req_valid,
    output logic                       o_inst_req_ready,
    input  axi_bridge_pkg::req_kind_e  i_inst_req_kind,
    input  logic [`AXI_ADDR_WIDTH-1:0] i_inst_req_addr,
    input  logic [`AXI_SIZE_WIDTH-1:0] i_inst_req_size,
    output logic                       o_inst_ret_valid,
    output logic [`AXI_DATA_WIDTH-1:0] o_inst_ret_data,
    output logic                       o_inst_ret_last,
    // data side
    input  logic                       i_data_req_valid,
    output logic                       o_data_req_ready,
    input  axi_bridge_pkg::req_kind_e  i_data_req_kind,
    input  logic [`AXI_ADDR_WIDTH-1:0] i_data_req_addr,
    input  logic [`AXI_SIZE_WIDTH-1:0] i_data_req_size,
    output logic                       o_data_ret_valid,
    output logic [`AXI_DATA_WIDTH-1:0] o_data_ret_data,
    output logic                       o_data_ret_last,
    // ar
    output logic                       o_arvalid,
    input  logic                       i_arready,
    output logic [`AXI_ADDR_WIDTH-1:0] o_araddr,
    output logic [`AXI_LEN_WIDTH-1:0]  o_arlen,
    output logic [`AXI_SIZE_WIDTH-1:0] o_arsize,
    output axi_bridge_pkg::axi_burst_e o_arburst,
    // r, always accepted
    input  logic                       i_rvalid,
    input  logic [`AXI_DATA_WIDTH-1:0] i_rdata,
    input  logic [`AXI_RESP_WIDTH-1:0] i_rresp,
    input  logic                       i_rlast,
    output logic                       o_resp_error
);
    logic                        inst_pend_valid;
    logic [`AXI_ADDR_WIDTH-1:0]  inst_pend_addr;
    logic [`AXI_LEN_WIDTH-1:0]   inst_pend_len;
    logic [`AXI_SIZE_WIDTH-1:0]  inst_pend_size;
    axi_bridge_pkg::axi_burst_e  inst_pend_burst;
    logic                        inst_take;
    logic                        data_pend_valid;
    logic [`AXI_ADDR_WIDTH-1:0]  data_pend_addr;
    logic [`AXI_LEN_WIDTH-1:0]   data_pend_len;
    logic [`AXI_SIZE_WIDTH-1:0]  data_pend_size;
    axi_bridge_pkg::axi_burst_e  data_pend_burst;
    logic                        data_take;
    // arbiter to router
    logic                        start;
    axi_bridge_pkg::req_owner_e  start_owner;
    logic [`LINE_BEAT_WIDTH-1:0] start_beats;
    logic                        done;

    read_req_decode u_inst_decode (
        .clk          (clk),
        .reset        (reset),
        .i_req_valid  (i_inst_req_valid),
        .o_req_ready  (o_inst_req_ready),
        .i_req_kind   (i_inst_req_kind),
        .i_req_addr   (i_inst_req_addr),
        .i_req_size   (i_inst_req_size),
        .o_pend_valid (inst_pend_valid),
        .o_pend_addr  (inst_pend_addr),
        .o_pend_len   (inst_pend_len),
        .o_pend_size  (inst_pend_size),
        .o_pend_burst (inst_pend_burst),
        .i_take       (inst_take)
    );

    read_req_decode u_data_decode (
        .clk          (clk),
        .reset        (reset),
        .i_req_valid  (i_data_req_valid),
        .o_req_ready  (o_data_req_ready),
        .i_req_kind   (i_data_req_kind),
        .i_req_addr   (i_data_req_addr),
        .i_req_size   (i_data_req_size),
        .o_pend_valid (data_pend_valid),
        .o_pend_addr  (data_pend_addr),
        .o_pend_len   (data_pend_len),
        .o_pend_size  (data_pend_size),
        .o_pend_burst (data_pend_burst),
        .i_take       (data_take)
    );

    read_arbiter u_arbiter (
        .clk               (clk),
        .reset             (reset),
        .i_inst_pend_valid (inst_pend_valid),
        .i_inst_pend_addr  (inst_pend_addr),
        .i_inst_pend_len   (inst_pend_len),
        .i_inst_pend_size  (inst_pend_size),
        .i_inst_pend_burst (inst_pend_burst),
        .i_data_pend_valid (data_pend_valid),
        .i_data_pend_addr  (data_pend_addr),
        .i_data_pend_len   (data_pend_len),
        .i_data_pend_size  (data_pend_size),
        .i_data_pend_burst (data_pend_burst),
        .o_inst_take       (inst_take),
        .o_data_take       (data_take),
        .o_arvalid         (o_arvalid),
        .i_arready         (i_arready),
        .o_araddr          (o_araddr),
        .o_arlen           (o_arlen),
        .o_arsize          (o_arsize),
        .o_arburst         (o_arburst),
        .o_start           (start),
        .o_start_owner     (start_owner),
        .o_start_beats     (start_beats),
        .i_done            (done)
    );

    read_return_router u_router (
        .clk              (clk),
        .reset            (reset),
        .i_start          (start),
        .i_start_owner    (start_owner),
        .i_start_beats    (start_beats),
        .i_rvalid         (i_rvalid),
        .i_rdata          (i_rdata),
        .i_rresp          (i_rresp),
        .i_rlast          (i_rlast),
        .o_done           (done),
        .o_inst_ret_valid (o_inst_ret_valid),
        .o_inst_ret_data  (o_inst_ret_data),
        .o_inst_ret_last  (o_inst_ret_last),
        .o_data_ret_valid (o_data_ret_valid),
        .o_data_ret_data  (o_data_ret_data),
        .o_data_ret_last  (o_data_ret_last),
        .o_resp_error     (o_resp_error)
    );

endmodule

// File: source/read_return_router.sv
// r channel return router
`include "axi_bridge_params.svh"

module read_return_router (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_start,
    input  axi_bridge_pkg::req_owner_e  i_start_owner,
    input  logic [`LINE_BEAT_WIDTH-1:0] i_start_beats,
    input  logic                        i_rvalid,
    input  logic [`AXI_DATA_WIDTH-1:0]  i_rdata,
    input  logic [`AXI_RESP_WIDTH-1:0]  i_rresp,
    input  logic                        i_rlast,
    output logic                        o_done,
    output logic                        o_inst_ret_valid,
    output logic [`AXI_DATA_WIDTH-1:0]  o_inst_ret_data,
    output logic                        o_inst_ret_last,
    output logic                        o_data_ret_valid,
    output logic [`AXI_DATA_WIDTH-1:0]  o_data_ret_data,
    output logic                        o_data_ret_last,
    output logic                        o_resp_error
);
    axi_bridge_pkg::req_owner_e  owner_q;
    logic [`LINE_BEAT_WIDTH-1:0] expect_q;
    logic [`LINE_BEAT_WIDTH-1:0] beat_cnt_q;
    logic [`LINE_BEAT_WIDTH-1:0] beat_num;
    logic                        is_final;
    logic                        inst_beat;
    logic                        data_beat;

    // 1-based index of the beat on the bus now
    assign beat_num = beat_cnt_q + 1'b1;
    assign is_final = (beat_num == expect_q);

    assign inst_beat = i_rvalid && owner_q == axi_bridge_pkg::OWNER_INST;
    assign data_beat = i_rvalid && owner_q == axi_bridge_pkg::OWNER_DATA;

    // arbiter may leave wait once the last beat shows up
    assign o_done = i_rvalid && i_rlast;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner_q <= axi_bridge_pkg::OWNER_INST;
            expect_q <= '0;
            beat_cnt_q <= '0;
        end else if (i_start) begin
            owner_q <= i_start_owner;
            expect_q <= i_start_beats;
            beat_cnt_q <= '0;
        end else if (i_rvalid) begin
            beat_cnt_q <= beat_num;
        end
    end

    // valid strobes, one cycle behind the r beat
    always_ff @(posedge clk) begin
        if (reset) begin
            o_inst_ret_valid <= 1'b0;
            o_data_ret_valid <= 1'b0;
        end else begin
            o_inst_ret_valid <= inst_beat;
            o_data_ret_valid <= data_beat;
        end
    end

    // payload only loads for its owner
    always_ff @(posedge clk) begin
        if (inst_beat) begin
            o_inst_ret_data <= i_rdata;
            o_inst_ret_last <= i_rlast;
        end
        if (data_beat) begin
            o_data_ret_data <= i_rdata;
            o_data_ret_last <= i_rlast;
        end
    end

    // sticky: early or late rlast, or any non-okay response
    always_ff @(posedge clk) begin
        if (reset) begin
            o_resp_error <= 1'b0;
        end else if (i_rvalid && (i_rlast != is_final || i_rresp != '0)) begin
            o_resp_error <= 1'b1;
        end
    end

endmodule

// File: source/read_arbiter.sv
// read arbiter and ar channel driver
`include "axi_bridge_params.svh"

module read_arbiter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         i_inst_pend_valid,
    input  logic [`AXI_ADDR_WIDTH-1:0]   i_inst_pend_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    i_inst_pend_len,
    input  logic [`AXI_SIZE_WIDTH-1:0]   i_inst_pend_size,
    input  axi_bridge_pkg::axi_burst_e   i_inst_pend_burst,
    input  logic                         i_data_pend_valid,
    input  logic [`AXI_ADDR_WIDTH-1:0]   i_data_pend_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    i_data_pend_len,
    input  logic [`AXI_SIZE_WIDTH-1:0]   i_data_pend_size,
    input  axi_bridge_pkg::axi_burst_e   i_data_pend_burst,
    output logic                         o_inst_take,
    output logic                         o_data_take,
    output logic                         o_arvalid,
    input  logic                         i_arready,
    output logic [`AXI_ADDR_WIDTH-1:0]   o_araddr,
    output logic [`AXI_LEN_WIDTH-1:0]    o_arlen,
    output logic [`AXI_SIZE_WIDTH-1:0]   o_arsize,
    output axi_bridge_pkg::axi_burst_e   o_arburst,
    output logic                         o_start,
    output axi_bridge_pkg::req_owner_e   o_start_owner,
    output logic [`LINE_BEAT_WIDTH-1:0]  o_start_beats,
    input  logic                         i_done
);
    axi_bridge_pkg::arb_state_e state_q;
    // owner of the current or most recent read
    axi_bridge_pkg::req_owner_e owner_q;
    logic                       any_pend;
    logic                       pick_data;
    logic                       ar_fire;

    assign any_pend = i_inst_pend_valid || i_data_pend_valid;

    // data wins ties, except right after its own read while inst waits
    assign pick_data = i_data_pend_valid &&
        (!i_inst_pend_valid || owner_q != axi_bridge_pkg::OWNER_DATA);

    assign o_arvalid = (state_q == axi_bridge_pkg::ARB_ISSUE);
    assign ar_fire = o_arvalid && i_arready;

    // release the winning decoder on the handshake
    assign o_inst_take = ar_fire && owner_q == axi_bridge_pkg::OWNER_INST;
    assign o_data_take = ar_fire && owner_q == axi_bridge_pkg::OWNER_DATA;

    // router setup, same cycle as the handshake
    assign o_start = ar_fire;
    assign o_start_owner = owner_q;
    assign o_start_beats = o_arlen[`LINE_BEAT_WIDTH-1:0] + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= axi_bridge_pkg::ARB_IDLE;
            // so the first tie goes to data
            owner_q <= axi_bridge_pkg::OWNER_INST;
        end else begin
            case (state_q)
                axi_bridge_pkg::ARB_IDLE: begin
                    if (any_pend) begin
                        state_q <= axi_bridge_pkg::ARB_ISSUE;
                        owner_q <= pick_data ? axi_bridge_pkg::OWNER_DATA
                                             : axi_bridge_pkg::OWNER_INST;
                    end
                end
                axi_bridge_pkg::ARB_ISSUE: begin
                    // hold until the slave takes it
                    if (i_arready) begin
                        state_q <= axi_bridge_pkg::ARB_WAIT;
                    end
                end
                axi_bridge_pkg::ARB_WAIT: begin
                    // single outstanding read
                    if (i_done) begin
                        state_q <= axi_bridge_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= axi_bridge_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // ar fields latched at selection, stable under back-pressure
    always_ff @(posedge clk) begin
        if (state_q == axi_bridge_pkg::ARB_IDLE && any_pend) begin
            if (pick_data) begin
                o_araddr <= i_data_pend_addr;
                o_arlen <= i_data_pend_len;
                o_arsize <= i_data_pend_size;
                o_arburst <= i_data_pend_burst;
            end else begin
                o_araddr <= i_inst_pend_addr;
                o_arlen <= i_inst_pend_len;
                o_arsize <= i_inst_pend_size;
                o_arburst <= i_inst_pend_burst;
            end
        end
    end

endmodule

// File: source/read_req_decode.sv
// read request decoder
`include "axi_bridge_params.svh"

module read_req_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_req_valid,
    output logic                       o_req_ready,
    input  axi_bridge_pkg::req_kind_e  i_req_kind,
    input  logic [`AXI_ADDR_WIDTH-1:0] i_req_addr,
    input  logic [`AXI_SIZE_WIDTH-1:0] i_req_size,
    output logic                       o_pend_valid,
    output logic [`AXI_ADDR_WIDTH-1:0] o_pend_addr,
    output logic [`AXI_LEN_WIDTH-1:0]  o_pend_len,
    output logic [`AXI_SIZE_WIDTH-1:0] o_pend_size,
    output axi_bridge_pkg::axi_burst_e o_pend_burst,
    input  logic                       i_take
);
    localparam int ADDR_W = `AXI_ADDR_WIDTH;
    localparam int LEN_W = `AXI_LEN_WIDTH;
    localparam int SIZE_W = `AXI_SIZE_WIDTH;
    localparam int WORD_BYTES = `AXI_DATA_WIDTH / 8;
    localparam int LINE_BYTES = `LINE_WORDS * WORD_BYTES;
    // byte offset bits inside one line
    localparam logic [ADDR_W-1:0] LINE_OFFSET = ADDR_W'(LINE_BYTES - 1);
    localparam logic [LEN_W-1:0] LINE_LEN = LEN_W'(`LINE_WORDS - 1);
    // arsize code of a full data-bus word
    localparam logic [SIZE_W-1:0] WORD_SIZE = SIZE_W'($clog2(WORD_BYTES));

    logic                       pend_valid_q;
    logic                       accept;
    logic [`AXI_ADDR_WIDTH-1:0] dec_addr;
    logic [`AXI_LEN_WIDTH-1:0]  dec_len;
    logic [`AXI_SIZE_WIDTH-1:0] dec_size;
    axi_bridge_pkg::axi_burst_e dec_burst;

    // one slot, so ready is just "slot empty"
    assign o_req_ready = !pend_valid_q;
    assign accept = i_req_valid && o_req_ready;
    assign o_pend_valid = pend_valid_q;

    // opcode to burst fields
    always_comb begin
        if (i_req_kind == axi_bridge_pkg::KIND_LINE) begin
            // line fill starts at the line base
            dec_addr = i_req_addr & ~LINE_OFFSET;
            dec_len = LINE_LEN;
            dec_size = WORD_SIZE;
            dec_burst = axi_bridge_pkg::BURST_INCR;
        end else begin
            // uncached word, one beat
            dec_addr = i_req_addr;
            dec_len = '0;
            dec_size = i_req_size;
            dec_burst = axi_bridge_pkg::BURST_FIXED;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid_q <= 1'b0;
        end else if (accept) begin
            pend_valid_q <= 1'b1;
        end else if (i_take) begin
            // freed on the ar handshake
            pend_valid_q <= 1'b0;
        end
    end

    // held fields
    always_ff @(posedge clk) begin
        if (accept) begin
            o_pend_addr <= dec_addr;
            o_pend_len <= dec_len;
            o_pend_size <= dec_size;
            o_pend_burst <= dec_burst;
        end
    end

endmodule

// File: source/axi_bridge_pkg.sv
// axi read bridge types
package axi_bridge_pkg;

    // which requester a transfer belongs to
    typedef enum logic {
        OWNER_INST = 1'b0,
        OWNER_DATA = 1'b1
    } req_owner_e;

    // request opcode
    typedef enum logic {
        KIND_SINGLE = 1'b0,
        KIND_LINE   = 1'b1
    } req_kind_e;

    // arburst encodings, wrap unused
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_e;

    // ar issue fsm
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'b00,
        ARB_ISSUE = 2'b01,
        ARB_WAIT  = 2'b10
    } arb_state_e;

endpackage

// File: include/axi_bridge_params.svh
// axi read bridge widths
`ifndef AXI_BRIDGE_PARAMS_SVH
`define AXI_BRIDGE_PARAMS_SVH

// axi read channel field widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_LEN_WIDTH 8
`define AXI_SIZE_WIDTH 3
`define AXI_RESP_WIDTH 2

// cache line geometry, in data-bus words
`define LINE_WORDS 4
// wide enough to hold LINE_WORDS itself
`define LINE_BEAT_WIDTH 3

`endif
